/* rtl/ep_mem_pkg.sv */
`default_nettype none

package ep_mem_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    typedef logic [31:0] word_t;              // Storage, payload and read data
    typedef logic [7:0]  byte_t;              // One byte lane
    typedef logic [3:0]  be_t;                // Bit 0 is the lowest-address byte

    localparam int unsigned ADDR_W_DEF = 7;   // 128-word aperture

    typedef logic [ADDR_W_DEF-1:0] idx_t;     // Word index carried by a commit

    // ------------------------------
    // Register map
    // ------------------------------
    localparam int unsigned REG_CTRL      = 0;
    localparam int unsigned REG_MWR_ADDR  = 1;
    localparam int unsigned REG_MWR_LEN   = 2;
    localparam int unsigned REG_MWR_COUNT = 3;
    localparam int unsigned REG_MWR_DATA  = 4;
    localparam int unsigned REG_STATUS    = 5;   // Read-only

    localparam int unsigned CTRL_INIT_RST_BIT   = 0;
    localparam int unsigned CTRL_MWR_START_BIT  = 16;
    localparam int unsigned STATUS_MWR_DONE_BIT = 0;

    // ------------------------------
    // Write path types
    // ------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        FETCH  = 2'd1,                        // Read old word
        MERGE  = 2'd2,                        // Build new word
        COMMIT = 2'd3                         // Word written to array
    } wr_state_e;

    typedef struct packed {
        logic  valid;
        idx_t  idx;
        word_t data;                          // Merged, in storage byte order
    } mem_wr_t;

    typedef struct packed {
        logic  start;
        logic  init_rst;
        word_t addr;
        word_t len;
        word_t count;
        word_t data;
    } mwr_ctrl_t;

endpackage

`default_nettype wire

/* rtl/ep_wr_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module ep_wr_ctrl #(
    parameter int unsigned ADDR_W = ep_mem_pkg::ADDR_W_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wr_en_i,
    input  wire logic [ADDR_W-1:0]     wr_addr_i,
    input  wire ep_mem_pkg::word_t     wr_data_i,
    input  wire ep_mem_pkg::be_t       wr_be_i,
    output logic                       wr_busy_o,
    output logic [ADDR_W-1:0]          fetch_addr_o,
    input  wire ep_mem_pkg::word_t     fetch_data_i,
    output ep_mem_pkg::mem_wr_t        commit_o
);

    localparam int unsigned NBYTES = $bits(ep_mem_pkg::be_t);
    localparam int unsigned WORD_W = $bits(ep_mem_pkg::word_t);

    ep_mem_pkg::wr_state_e state_q;
    logic                  accept;
    logic                  commit_vld_q;

    logic [ADDR_W-1:0]     addr_q;        // Latched at accept
    ep_mem_pkg::word_t     data_q;
    ep_mem_pkg::be_t       be_q;
    ep_mem_pkg::word_t     fetch_q;       // Old stored word
    ep_mem_pkg::word_t     merged;
    ep_mem_pkg::word_t     commit_data_q;

    assign accept = wr_en_i && (state_q == ep_mem_pkg::IDLE);

    // ------------------------------
    // Write FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= ep_mem_pkg::IDLE;
            commit_vld_q <= 1'b0;
        end else begin
            commit_vld_q <= 1'b0;                     // Single-cycle strobe
            case (state_q)
                ep_mem_pkg::IDLE: begin
                    if (accept) begin
                        state_q <= ep_mem_pkg::FETCH;
                    end
                end
                ep_mem_pkg::FETCH: begin
                    state_q <= ep_mem_pkg::MERGE;
                end
                ep_mem_pkg::MERGE: begin
                    state_q      <= ep_mem_pkg::COMMIT;
                    commit_vld_q <= 1'b1;
                end
                default: begin
                    state_q <= ep_mem_pkg::IDLE;      // COMMIT done this edge
                end
            endcase
        end
    end

    // Request, old word and merged word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= wr_addr_i;
            data_q <= wr_data_i;
            be_q   <= wr_be_i;
        end
        if (state_q == ep_mem_pkg::FETCH) begin
            fetch_q <= fetch_data_i;
        end
        if (state_q == ep_mem_pkg::MERGE) begin
            commit_data_q <= merged;
        end
    end

    // ------------------------------
    // Byte swizzle and merge
    // ------------------------------
    // Payload byte n sits n lanes down from the top; stored byte n sits in lane n
    always_comb begin
        for (int n = 0; n < NBYTES; n++) begin
            ep_mem_pkg::byte_t pay_b;
            pay_b = data_q[WORD_W-1-8*n -: 8];
            merged[8*n +: 8] = be_q[n] ? pay_b : fetch_q[8*n +: 8];
        end
    end

    assign fetch_addr_o = addr_q;
    assign wr_busy_o    = wr_en_i || (state_q != ep_mem_pkg::IDLE);

    assign commit_o = '{
        valid: commit_vld_q,
        idx:   ep_mem_pkg::idx_t'(addr_q),
        data:  commit_data_q
    };

endmodule

`default_nettype wire

/* rtl/ep_reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module ep_reg_file #(
    parameter int unsigned ADDR_W = ep_mem_pkg::ADDR_W_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [ADDR_W-1:0]     rd_addr_i,
    output ep_mem_pkg::word_t          rd_data_o,
    input  wire logic [ADDR_W-1:0]     fetch_addr_i,
    output ep_mem_pkg::word_t          fetch_data_o,
    input  wire ep_mem_pkg::mem_wr_t   commit_i,
    input  wire logic                  mwr_done_i,
    output ep_mem_pkg::mwr_ctrl_t      mwr_ctrl_o
);

    localparam int unsigned DEPTH = 2 ** ADDR_W;

    // Register indices at aperture width
    localparam logic [ADDR_W-1:0] A_CTRL      = ADDR_W'(ep_mem_pkg::REG_CTRL);
    localparam logic [ADDR_W-1:0] A_MWR_ADDR  = ADDR_W'(ep_mem_pkg::REG_MWR_ADDR);
    localparam logic [ADDR_W-1:0] A_MWR_LEN   = ADDR_W'(ep_mem_pkg::REG_MWR_LEN);
    localparam logic [ADDR_W-1:0] A_MWR_COUNT = ADDR_W'(ep_mem_pkg::REG_MWR_COUNT);
    localparam logic [ADDR_W-1:0] A_MWR_DATA  = ADDR_W'(ep_mem_pkg::REG_MWR_DATA);
    localparam logic [ADDR_W-1:0] A_STATUS    = ADDR_W'(ep_mem_pkg::REG_STATUS);

    ep_mem_pkg::word_t mem_q [DEPTH];
    logic [ADDR_W-1:0] wr_idx;
    logic              wr_en;
    logic              ctrl_hit;          // Any commit to REG_CTRL
    logic              done_q;            // Sticky DMA write done
    ep_mem_pkg::word_t status_word;

    assign wr_idx   = commit_i.idx[ADDR_W-1:0];
    assign wr_en    = commit_i.valid && (wr_idx != A_STATUS);
    assign ctrl_hit = commit_i.valid && (wr_idx == A_CTRL);

    // ------------------------------
    // Storage array
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en) begin
            mem_q[wr_idx] <= commit_i.data;
        end
    end

    // ------------------------------
    // Status
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (mwr_done_i) begin
            done_q <= 1'b1;                   // Set wins over clear
        end else if (ctrl_hit) begin
            done_q <= 1'b0;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[ep_mem_pkg::STATUS_MWR_DONE_BIT] = done_q;
    end

    // Host reads see the status word in place of the array entry
    assign rd_data_o    = (rd_addr_i == A_STATUS) ? status_word : mem_q[rd_addr_i];
    assign fetch_data_o = mem_q[fetch_addr_i];

    // ------------------------------
    // DMA write engine controls
    // ------------------------------
    assign mwr_ctrl_o.start    = mem_q[A_CTRL][ep_mem_pkg::CTRL_MWR_START_BIT];
    assign mwr_ctrl_o.init_rst = mem_q[A_CTRL][ep_mem_pkg::CTRL_INIT_RST_BIT];
    assign mwr_ctrl_o.addr     = mem_q[A_MWR_ADDR];     // Stored byte order
    assign mwr_ctrl_o.len      = mem_q[A_MWR_LEN];
    assign mwr_ctrl_o.count    = mem_q[A_MWR_COUNT];
    assign mwr_ctrl_o.data     = mem_q[A_MWR_DATA];

endmodule

`default_nettype wire

/* rtl/ep_mem_access.sv */
`timescale 1ns/100ps
`default_nettype none

module ep_mem_access #(
    parameter int unsigned ADDR_W = ep_mem_pkg::ADDR_W_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // Host read
    input  wire logic [ADDR_W-1:0]     addr_i,
    input  wire ep_mem_pkg::be_t       rd_be_i,
    output ep_mem_pkg::word_t          rd_data_o,

    // Host write
    input  wire ep_mem_pkg::be_t       wr_be_i,
    input  wire ep_mem_pkg::word_t     wr_data_i,
    input  wire logic                  wr_en_i,
    output logic                       wr_busy_o,

    // DMA write engine
    input  wire logic                  mwr_done_i,
    output ep_mem_pkg::mwr_ctrl_t      mwr_ctrl_o
);

    localparam int unsigned NBYTES = $bits(ep_mem_pkg::be_t);
    localparam int unsigned WORD_W = $bits(ep_mem_pkg::word_t);

    logic [ADDR_W-1:0]   fetch_addr;
    ep_mem_pkg::word_t   fetch_data;
    ep_mem_pkg::mem_wr_t commit;
    ep_mem_pkg::word_t   stored_rd;       // Raw word, storage byte order

    // ------------------------------
    // Host read masking
    // ------------------------------
    // Stored byte n goes back to payload lane n from the top
    always_comb begin
        for (int n = 0; n < NBYTES; n++) begin
            ep_mem_pkg::byte_t lane;
            lane = stored_rd[8*n +: 8];
            rd_data_o[WORD_W-1-8*n -: 8] = rd_be_i[n] ? lane : 8'h00;
        end
    end

    ep_wr_ctrl #(
        .ADDR_W (ADDR_W)
    ) u_wr_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en_i      (wr_en_i),
        .wr_addr_i    (addr_i),
        .wr_data_i    (wr_data_i),
        .wr_be_i      (wr_be_i),
        .wr_busy_o    (wr_busy_o),
        .fetch_addr_o (fetch_addr),
        .fetch_data_i (fetch_data),
        .commit_o     (commit)
    );

    ep_reg_file #(
        .ADDR_W (ADDR_W)
    ) u_reg_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_addr_i    (addr_i),
        .rd_data_o    (stored_rd),
        .fetch_addr_i (fetch_addr),
        .fetch_data_o (fetch_data),
        .commit_i     (commit),
        .mwr_done_i   (mwr_done_i),
        .mwr_ctrl_o   (mwr_ctrl_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS  = 100,
    parameter int unsigned RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/ep_mem_access_props.sv */
`timescale 1ns/100ps
`default_nettype none

module ep_mem_access_props (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  wr_en_i,
    input wire logic                  wr_busy_i,
    input wire ep_mem_pkg::wr_state_e state_i,
    input wire ep_mem_pkg::mem_wr_t   commit_i
);

    logic        accept;
    int unsigned prop_errors = 0;         // Failed assertion count

    assign accept = wr_en_i && (state_i == ep_mem_pkg::IDLE);

    // Busy released once the write has committed
    a_idle_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_i.valid ##1 !wr_en_i) |-> !wr_busy_i)
        else begin
            $error("wr_busy_o still high after the commit without wr_en_i");
            prop_errors++;
        end

    // Accept at T, commit strobe seen at T+3 for one cycle
    a_commit_once: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##3 commit_i.valid ##1 !commit_i.valid)
        else begin
            $error("Commit strobe missing or longer than one cycle");
            prop_errors++;
        end

    a_no_wr_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i != ep_mem_pkg::IDLE) |-> !wr_en_i)
        else begin
            $error("wr_en_i offered while the write FSM is not IDLE");
            prop_errors++;
        end

endmodule

`default_nettype wire

/* testbench/tb_ep_mem_access.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ep_mem_access;

    localparam int unsigned ADDR_W = ep_mem_pkg::ADDR_W_DEF;
    localparam int unsigned DEPTH  = 2 ** ADDR_W;
    localparam int unsigned BUSY_TIMEOUT = 20;         // Cycles per wait

    logic                  clk;
    logic                  rst_n;
    logic [ADDR_W-1:0]     addr_i;
    ep_mem_pkg::be_t       rd_be_i;
    ep_mem_pkg::word_t     rd_data_o;
    ep_mem_pkg::be_t       wr_be_i;
    ep_mem_pkg::word_t     wr_data_i;
    logic                  wr_en_i;
    logic                  wr_busy_o;
    logic                  mwr_done_i;
    ep_mem_pkg::mwr_ctrl_t mwr_ctrl_o;

    ep_mem_pkg::word_t     model_mem [DEPTH];          // Stored byte order
    logic                  model_done;
    logic                  check_en;
    logic [31:0]           lfsr_q;
    int unsigned           checks;
    int unsigned           value_errors;
    int unsigned           timeouts;

    tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    ep_mem_access #(.ADDR_W(ADDR_W)) u_dut (
        .clk (clk), .rst_n (rst_n), .addr_i (addr_i), .rd_be_i (rd_be_i),
        .rd_data_o (rd_data_o), .wr_be_i (wr_be_i), .wr_data_i (wr_data_i),
        .wr_en_i (wr_en_i), .wr_busy_o (wr_busy_o), .mwr_done_i (mwr_done_i),
        .mwr_ctrl_o (mwr_ctrl_o)
    );

    bind ep_wr_ctrl ep_mem_access_props u_props (
        .clk (clk), .rst_n (rst_n), .wr_en_i (wr_en_i), .wr_busy_i (wr_busy_o),
        .state_i (state_q), .commit_i (commit_o)
    );

    // ------------------------------
    // Random source
    // ------------------------------
    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    // Payload byte n lives n lanes down from the top, stored byte n in lane n
    function automatic ep_mem_pkg::word_t merge_ref(input ep_mem_pkg::word_t old_w,
            input ep_mem_pkg::word_t pay, input ep_mem_pkg::be_t be);
        ep_mem_pkg::word_t w;
        w = old_w;
        for (int n = 0; n < 4; n++) begin
            if (be[n]) w[8*n +: 8] = pay[31-8*n -: 8];
        end
        return w;
    endfunction

    function automatic ep_mem_pkg::word_t read_ref(input logic [ADDR_W-1:0] a,
            input ep_mem_pkg::be_t be);
        ep_mem_pkg::word_t stored;
        ep_mem_pkg::word_t r;
        stored = model_mem[a];
        if (a == ep_mem_pkg::REG_STATUS) begin
            stored = '0;
            stored[ep_mem_pkg::STATUS_MWR_DONE_BIT] = model_done;
        end
        r = '0;
        for (int n = 0; n < 4; n++) begin
            if (be[n]) r[31-8*n -: 8] = stored[8*n +: 8];  // Back to payload order
        end
        return r;
    endfunction

    function automatic ep_mem_pkg::mwr_ctrl_t ctrl_ref();
        ep_mem_pkg::mwr_ctrl_t c;
        c.start    = model_mem[ep_mem_pkg::REG_CTRL][ep_mem_pkg::CTRL_MWR_START_BIT];
        c.init_rst = model_mem[ep_mem_pkg::REG_CTRL][ep_mem_pkg::CTRL_INIT_RST_BIT];
        c.addr     = model_mem[ep_mem_pkg::REG_MWR_ADDR];
        c.len      = model_mem[ep_mem_pkg::REG_MWR_LEN];
        c.count    = model_mem[ep_mem_pkg::REG_MWR_COUNT];
        c.data     = model_mem[ep_mem_pkg::REG_MWR_DATA];
        return c;
    endfunction

    // ------------------------------
    // Comparison
    // ------------------------------
    always @(negedge clk) begin : compare
        ep_mem_pkg::word_t     exp_rd;
        ep_mem_pkg::mwr_ctrl_t exp_ctrl;
        if (check_en) begin
            exp_rd   = read_ref(addr_i, rd_be_i);
            exp_ctrl = ctrl_ref();
            checks++;
            assert (rd_data_o === exp_rd) else begin
                value_errors++;
                $display("Fail at %0t: word %0d be %b read %h, expected %h",
                         $time, addr_i, rd_be_i, rd_data_o, exp_rd);
            end
            assert (mwr_ctrl_o === exp_ctrl) else begin
                value_errors++;
                $display("Fail at %0t: mwr_ctrl_o %h, expected %h", $time, mwr_ctrl_o, exp_ctrl);
            end
            assert (wr_busy_o === 1'b0) else begin
                value_errors++;
                $display("Fail at %0t: wr_busy_o high while idle", $time);
            end
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic issue_read(input logic [ADDR_W-1:0] a, input ep_mem_pkg::be_t be);
        @(posedge clk);
        addr_i   <= a;
        rd_be_i  <= be;
        check_en <= 1'b1;
        @(posedge clk);
        check_en <= 1'b0;
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] a, input ep_mem_pkg::word_t d,
            input ep_mem_pkg::be_t be);
        int unsigned cnt;
        @(posedge clk);
        addr_i    <= a;
        wr_data_i <= d;
        wr_be_i   <= be;
        wr_en_i   <= 1'b1;
        @(posedge clk);
        wr_en_i <= 1'b0;                               // One-cycle request
        cnt = 0;
        @(negedge clk);
        while (wr_busy_o && cnt < BUSY_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (wr_busy_o) begin
            timeouts++;
            $display("Timeout: wr_busy_o did not fall after a write to word %0d", a);
        end
        if (a != ep_mem_pkg::REG_STATUS) model_mem[a] = merge_ref(model_mem[a], d, be);
        if (a == ep_mem_pkg::REG_CTRL) model_done = 1'b0;
    endtask

    task automatic pulse_done();
        @(posedge clk);
        mwr_done_i <= 1'b1;
        @(posedge clk);
        mwr_done_i <= 1'b0;
        @(negedge clk);
        model_done = 1'b1;
    endtask

    function automatic logic [ADDR_W-1:0] scratch_addr();
        return ADDR_W'(6 + take_bits(ADDR_W) % (DEPTH - 6));   // Above the DMA block
    endfunction

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int unsigned       cnt;
        logic [ADDR_W-1:0] a;
        addr_i = '0;
        rd_be_i = '0;
        wr_be_i = '0;
        wr_data_i = '0;
        wr_en_i = 1'b0;
        mwr_done_i = 1'b0;
        check_en = 1'b0;
        lfsr_q = 32'h88ed;
        checks = 0;
        value_errors = 0;
        timeouts = 0;
        model_done = 1'b0;
        for (int i = 0; i < DEPTH; i++) model_mem[i] = '0;

        cnt = 0;
        @(posedge clk);
        while (!rst_n && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end

        for (int i = 0; i < DEPTH; i++) issue_read(ADDR_W'(i), 4'hF);   // Reset state

        a = scratch_addr();                            // Full-enable round trip
        do_write(a, take_bits(32), 4'hF);
        issue_read(a, 4'hF);

        repeat (40) begin                              // Random merge and mask
            a = scratch_addr();
            do_write(a, take_bits(32), ep_mem_pkg::be_t'(take_bits(4)));
            issue_read(a, ep_mem_pkg::be_t'(take_bits(4)));
        end

        for (int r = ep_mem_pkg::REG_MWR_ADDR; r <= ep_mem_pkg::REG_MWR_DATA; r++) begin
            do_write(ADDR_W'(r), take_bits(32), 4'hF);
            issue_read(ADDR_W'(r), 4'hF);
        end
        do_write(ADDR_W'(ep_mem_pkg::REG_CTRL), 32'h0100_0000, 4'hF);  // init_rst
        issue_read(ADDR_W'(ep_mem_pkg::REG_CTRL), 4'hF);
        do_write(ADDR_W'(ep_mem_pkg::REG_CTRL), 32'h0000_0100, 4'hF);  // start
        issue_read(ADDR_W'(ep_mem_pkg::REG_CTRL), 4'hF);

        pulse_done();                                  // Sticky done flag
        issue_read(ADDR_W'(ep_mem_pkg::REG_STATUS), 4'hF);
        do_write(ADDR_W'(ep_mem_pkg::REG_STATUS), take_bits(32), 4'hF);
        issue_read(ADDR_W'(ep_mem_pkg::REG_STATUS), 4'hF);
        do_write(ADDR_W'(ep_mem_pkg::REG_CTRL), 32'h0000_0000, 4'hF);
        issue_read(ADDR_W'(ep_mem_pkg::REG_STATUS), 4'hF);

        repeat (2) @(posedge clk);
        $display("Checks: %0d, value errors: %0d, timeouts: %0d, assertion errors: %0d",
                 checks, value_errors, timeouts, u_dut.u_wr_ctrl.u_props.prop_errors);
        if (value_errors == 0 && timeouts == 0
                && u_dut.u_wr_ctrl.u_props.prop_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
rtl/ep_mem_pkg.sv
rtl/ep_wr_ctrl.sv
rtl/ep_reg_file.sv
rtl/ep_mem_access.sv
testbench/tb_clk_gen.sv
testbench/ep_mem_access_props.sv
testbench/tb_ep_mem_access.sv

/* Bender.yml */
package:
  name: ep_mem_access

sources:
  - target: rtl
    files:
      - rtl/ep_mem_pkg.sv
      - rtl/ep_wr_ctrl.sv
      - rtl/ep_reg_file.sv
      - rtl/ep_mem_access.sv

  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/ep_mem_access_props.sv
      - testbench/tb_ep_mem_access.sv
